/* logic/geom_pkg.sv */
package geom_pkg;

  // --------------------
  // Triangle attributes
  // --------------------

  // Four 32-bit vertex words, word 0 in the low bits.
  typedef logic [3:0][31:0] position_t;

  // Packed normal, x in [11:8], y in [7:4], z in [3:0].
  typedef logic [11:0] normal_t;

  typedef logic [11:0] material_t;

  // Width of the cull counter.
  typedef logic [15:0] count_t;

  // One normal component, 4-bit two's complement.
  localparam int NORMAL_COMP_W = 4;
  typedef logic signed [NORMAL_COMP_W-1:0] normal_comp_t;

  function automatic normal_comp_t normal_z(normal_t n);
    return normal_comp_t'(n[NORMAL_COMP_W-1:0]);
  endfunction

endpackage

/* logic/fifo_pkg.sv */
package fifo_pkg;

  // --------------------
  // Triangle FIFO
  // --------------------

  // Depth 1024.
  localparam int DEFAULT_ADDR_W = 10;

  // Read side sequencing.
  //   fifo_idle   no triangle locked
  //   fifo_lock   read address held, RAM output settling
  //   fifo_offer  valid shown to the consumer
  typedef enum logic [1:0] {
    fifo_idle,
    fifo_lock,
    fifo_offer
  } fifo_state_t;

endpackage

/* logic/triangle_if.sv */
interface triangle_if;

  import geom_pkg::*;

  // One complete triangle with a valid/ready handshake.
  logic      valid;
  logic      ready;
  position_t position;
  normal_t   normal;
  material_t material;

  modport source (
    output valid,
    output position,
    output normal,
    output material,
    input  ready
  );

  modport sink (
    input  valid,
    input  position,
    input  normal,
    input  material,
    output ready
  );

endinterface

/* logic/attr_ram.sv */
module attr_ram #(
  parameter int WIDTH  = 12,
  parameter int ADDR_W = 10
) (
  input  wire               clk_in,

  input  wire               we,
  input  wire  [ADDR_W-1:0] waddr,
  input  wire  [WIDTH-1:0]  wdata,

  input  wire  [ADDR_W-1:0] raddr,
  output logic [WIDTH-1:0]  rdata
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [WIDTH-1:0] mem [DEPTH];

  // Write port.
  always_ff @(posedge clk_in) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read port, one cycle of latency.
  always_ff @(posedge clk_in) begin
    rdata <= mem[raddr];
  end

endmodule

/* logic/triangle_fifo.sv */
module triangle_fifo #(
  parameter int ADDR_W = 10
) (
  input  wire                  clk_in,
  input  wire                  rst_in,

  input  wire                  position_valid,
  input  wire geom_pkg::position_t position,
  input  wire                  normal_valid,
  input  wire geom_pkg::normal_t   normal,
  input  wire                  material_valid,
  input  wire geom_pkg::material_t material,

  triangle_if.source           out
);

  import geom_pkg::*;
  import fifo_pkg::*;

  // Stream index: 0 position, 1 normal, 2 material.
  logic [2:0]             wr_strobe;
  logic [2:0]             wr_full;
  logic [2:0]             wr_en;
  logic [2:0]             has_entry;
  logic [2:0][ADDR_W-1:0] wr_ptr;
  logic [2:0][ADDR_W-1:0] wr_next;
  logic [ADDR_W-1:0]      rd_ptr;
  logic                   non_empty;
  fifo_state_t            state;

  assign wr_strobe = {material_valid, normal_valid, position_valid};

  // --------------------
  // Write side
  // --------------------

  for (genvar i = 0; i < 3; i++) begin : g_stream
    assign wr_next[i]   = wr_ptr[i] + 1'b1;
    // One slot stays free so full and empty differ.
    assign wr_full[i]   = (wr_next[i] == rd_ptr);
    assign wr_en[i]     = wr_strobe[i] && !wr_full[i];
    assign has_entry[i] = (wr_ptr[i] != rd_ptr);
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (wr_en[i]) begin
          wr_ptr[i] <= wr_next[i];
        end
      end
    end
  end

  // A triangle is complete once every stream has written it.
  assign non_empty = &has_entry;

  // --------------------
  // Read side
  // --------------------

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state  <= fifo_idle;
      rd_ptr <= '0;
    end else begin
      case (state)
        fifo_idle: begin
          if (non_empty) begin
            state <= fifo_lock;
          end
        end
        fifo_lock: begin
          state <= fifo_offer;
        end
        fifo_offer: begin
          if (out.ready) begin
            rd_ptr <= rd_ptr + 1'b1;
            state  <= fifo_idle;
          end
        end
        default: begin
          state <= fifo_idle;
        end
      endcase
    end
  end

  assign out.valid = (state == fifo_offer);

  attr_ram #(
    .WIDTH ($bits(position_t)),
    .ADDR_W(ADDR_W)
  ) position_ram (
    .clk_in(clk_in),
    .we    (wr_en[0]),
    .waddr (wr_ptr[0]),
    .wdata (position),
    .raddr (rd_ptr),
    .rdata (out.position)
  );

  attr_ram #(
    .WIDTH ($bits(normal_t)),
    .ADDR_W(ADDR_W)
  ) normal_ram (
    .clk_in(clk_in),
    .we    (wr_en[1]),
    .waddr (wr_ptr[1]),
    .wdata (normal),
    .raddr (rd_ptr),
    .rdata (out.normal)
  );

  attr_ram #(
    .WIDTH ($bits(material_t)),
    .ADDR_W(ADDR_W)
  ) material_ram (
    .clk_in(clk_in),
    .we    (wr_en[2]),
    .waddr (wr_ptr[2]),
    .wdata (material),
    .raddr (rd_ptr),
    .rdata (out.material)
  );

  // Producers must never write into a full stream.
  assert property (@(posedge clk_in) disable iff (rst_in)
    !(|(wr_strobe & wr_full)))
    else $error("triangle_fifo: write to full stream dropped");

  // Offered triangle holds until the consumer takes it.
  assert property (@(posedge clk_in) disable iff (rst_in)
    out.valid && !out.ready |=> out.valid && $stable(out.position)
      && $stable(out.normal) && $stable(out.material))
    else $error("triangle_fifo: offer changed before transfer");

endmodule

/* logic/backface_cull.sv */
module backface_cull (
  input  wire                  clk_in,
  input  wire                  rst_in,
  input  wire                  cull_enable,

  triangle_if.sink             in,

  output logic                 tri_valid,
  input  wire                  tri_ready,
  output geom_pkg::position_t  tri_position,
  output geom_pkg::normal_t    tri_normal,
  output geom_pkg::material_t  tri_material,

  output geom_pkg::count_t     culled_count
);

  import geom_pkg::*;

  normal_comp_t z_comp;
  logic         back_facing;
  logic         accept;

  // Facing away when z is zero or negative.
  assign z_comp      = normal_z(in.normal);
  assign back_facing = cull_enable && (z_comp <= 4'sd0);

  // Take a new triangle when the register is empty or draining.
  assign in.ready = !tri_valid || tri_ready;
  assign accept   = in.valid && in.ready;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      tri_valid    <= 1'b0;
      culled_count <= '0;
    end else begin
      if (accept) begin
        tri_valid <= !back_facing;
        if (back_facing) begin
          culled_count <= culled_count + 1'b1;
        end
      end else if (tri_ready) begin
        tri_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept && !back_facing) begin
      tri_position <= in.position;
      tri_normal   <= in.normal;
      tri_material <= in.material;
    end
  end

  // Output holds while the downstream stalls.
  assert property (@(posedge clk_in) disable iff (rst_in)
    tri_valid && !tri_ready |=> tri_valid && $stable(tri_position)
      && $stable(tri_normal) && $stable(tri_material))
    else $error("backface_cull: output changed under back-pressure");

endmodule

/* logic/triangle_stream_top.sv */
module triangle_stream_top #(
  parameter int ADDR_W = fifo_pkg::DEFAULT_ADDR_W
) (
  input  wire                      clk_in,
  input  wire                      rst_in,

  // Attribute streams.
  input  wire                      position_valid,
  input  wire geom_pkg::position_t position,
  input  wire                      normal_valid,
  input  wire geom_pkg::normal_t   normal,
  input  wire                      material_valid,
  input  wire geom_pkg::material_t material,

  input  wire                      cull_enable,

  // Triangle output.
  output logic                     tri_valid,
  input  wire                      tri_ready,
  output geom_pkg::position_t      tri_position,
  output geom_pkg::normal_t        tri_normal,
  output geom_pkg::material_t      tri_material,

  output geom_pkg::count_t         culled_count
);

  triangle_if fifo_to_cull ();

  triangle_fifo #(
    .ADDR_W(ADDR_W)
  ) fifo (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .position_valid(position_valid),
    .position      (position),
    .normal_valid  (normal_valid),
    .normal        (normal),
    .material_valid(material_valid),
    .material      (material),
    .out           (fifo_to_cull.source)
  );

  backface_cull cull (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .cull_enable (cull_enable),
    .in          (fifo_to_cull.sink),
    .tri_valid   (tri_valid),
    .tri_ready   (tri_ready),
    .tri_position(tri_position),
    .tri_normal  (tri_normal),
    .tri_material(tri_material),
    .culled_count(culled_count)
  );

endmodule

/* bench/triangle_stream_tb.sv */
module triangle_stream_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ENTRIES      = 12;
  localparam int CYCLES_PER_ENTRY = 200;
  localparam int FIFO_ROOM        = 15;

  typedef struct packed {
    logic         cull;
    logic [3:0]   pos_delay;
    logic [3:0]   nrm_delay;
    logic [3:0]   mat_delay;
    logic [11:0]  material;
    logic [11:0]  normal;
    logic [127:0] position;
  } entry_t;

  logic         clk_in = 1'b0;
  logic         rst_in;
  logic [2:0]   strobe;
  logic [127:0] position;
  logic [11:0]  normal;
  logic [11:0]  material;
  logic         cull_enable;
  logic         tri_valid;
  logic         tri_ready;
  logic [127:0] tri_position;
  logic [11:0]  tri_normal;
  logic [11:0]  tri_material;
  logic [15:0]  culled_count;

  entry_t       entries [NUM_ENTRIES];
  int           num_loaded;
  int           exp_q [$];
  int           written [3];
  int           received;
  int           culled_expected;
  int           phase_start;
  int           phase_end;
  int           exp_idx;
  logic [31:0]  lcg_state;
  logic         hold_pending;
  logic [127:0] held_position;
  logic [11:0]  held_normal;
  logic [11:0]  held_material;

  triangle_stream_top #(
    .ADDR_W(4)
  ) uut (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .position_valid(strobe[0]),
    .position      (position),
    .normal_valid  (strobe[1]),
    .normal        (normal),
    .material_valid(strobe[2]),
    .material      (material),
    .cull_enable   (cull_enable),
    .tri_valid     (tri_valid),
    .tri_ready     (tri_ready),
    .tri_position  (tri_position),
    .tri_normal    (tri_normal),
    .tri_material  (tri_material),
    .culled_count  (culled_count)
  );

  always #5 clk_in = ~clk_in;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Back-facing when z, the low nibble as two's complement, is not positive.
  function automatic logic is_back_facing(input logic [11:0] n, input logic cull);
    logic signed [3:0] z;
    z = n[3:0];
    return cull && (z <= 0);
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic add_entry(input logic [127:0] pos, input logic [11:0] nrm,
                           input logic [11:0] mat, input int dp, input int dn,
                           input int dm, input logic cull);
    entries[num_loaded].position  = pos;
    entries[num_loaded].normal    = nrm;
    entries[num_loaded].material  = mat;
    entries[num_loaded].pos_delay = 4'(dp);
    entries[num_loaded].nrm_delay = 4'(dn);
    entries[num_loaded].mat_delay = 4'(dm);
    entries[num_loaded].cull      = cull;
    num_loaded++;
  endtask

  // One producer. Stream 0 position, 1 normal, 2 material.
  task automatic write_stream(input int stream, input int first, input int last);
    int delay;
    for (int i = first; i <= last; i++) begin
      case (stream)
        0:       delay = entries[i].pos_delay;
        1:       delay = entries[i].nrm_delay;
        default: delay = entries[i].mat_delay;
      endcase
      repeat (delay) @(negedge clk_in);
      while (written[stream] - received - int'(culled_count) >= FIFO_ROOM) begin
        @(negedge clk_in);
      end
      case (stream)
        0:       position = entries[i].position;
        1:       normal = entries[i].normal;
        default: material = entries[i].material;
      endcase
      strobe[stream] = 1'b1;
      @(negedge clk_in);
      strobe[stream] = 1'b0;
      written[stream]++;
    end
  endtask

  // --------------------
  // Output monitor
  // --------------------
  always @(negedge clk_in) begin
    lcg_state = lcg_next(lcg_state);
    tri_ready = (lcg_state[31:30] != 2'b00);
    if (!rst_in) begin
      if (hold_pending) begin
        check_value("stall valid", 1'b1, tri_valid);
        check_value("stall position", held_position, tri_position);
        check_value("stall normal", held_normal, tri_normal);
        check_value("stall material", held_material, tri_material);
      end
      if (tri_valid && tri_ready) begin
        if (exp_q.size() == 0) begin
          $display("Error: a triangle left the output when none was expected");
          $display("Testbench failed");
          $fatal(1, "unexpected output");
        end
        exp_idx = exp_q.pop_front();
        check_value($sformatf("triangle %0d position", exp_idx),
                    entries[exp_idx].position, tri_position);
        check_value($sformatf("triangle %0d normal", exp_idx),
                    entries[exp_idx].normal, tri_normal);
        check_value($sformatf("triangle %0d material", exp_idx),
                    entries[exp_idx].material, tri_material);
        received++;
      end
      hold_pending  = tri_valid && !tri_ready;
      held_position = tri_position;
      held_normal   = tri_normal;
      held_material = tri_material;
    end
  end

  initial begin
    repeat (CYCLES_PER_ENTRY * NUM_ENTRIES) @(posedge clk_in);
    $display("Timeout: expected triangles never arrived on the output");
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_in       = 1'b1;
    strobe       = '0;
    position     = '0;
    normal       = '0;
    material     = '0;
    cull_enable  = 1'b0;
    tri_ready    = 1'b0;
    lcg_state    = 32'h5bf0;
    hold_pending = 1'b0;
    received     = 0;
    num_loaded   = 0;
    written      = '{0, 0, 0};

    // position, normal, material, delays (pos, nrm, mat), cull_enable.
    add_entry(128'h00000003_00000002_00000001_00000000, 12'h123, 12'h0a1, 0, 3, 1, 1'b1);
    add_entry(128'h10000003_10000002_10000001_10000000, 12'h450, 12'h0a2, 2, 0, 5, 1'b1);
    add_entry(128'h20000003_20000002_20000001_20000000, 12'hf0f, 12'h0a3, 1, 4, 0, 1'b1);
    add_entry(128'h30000003_30000002_30000001_30000000, 12'h017, 12'h0a4, 3, 1, 2, 1'b1);
    add_entry(128'h40000003_40000002_40000001_40000000, 12'h7a8, 12'h0a5, 0, 0, 0, 1'b1);
    add_entry(128'h50000003_50000002_50000001_50000000, 12'h001, 12'h0a6, 6, 2, 1, 1'b1);
    add_entry(128'h60000003_60000002_60000001_60000000, 12'h0f0, 12'hb01, 0, 5, 2, 1'b0);
    add_entry(128'h70000003_70000002_70000001_70000000, 12'h33c, 12'hb02, 4, 0, 0, 1'b0);
    add_entry(128'h80000003_80000002_80000001_80000000, 12'habc, 12'hb03, 1, 1, 7, 1'b0);
    add_entry(128'h90000003_90000002_90000001_90000000, 12'h552, 12'hb04, 0, 2, 0, 1'b0);
    add_entry(128'ha0000003_a0000002_a0000001_a0000000, 12'h889, 12'hc01, 2, 0, 3, 1'b1);
    add_entry(128'hb0000003_b0000002_b0000001_b0000000, 12'hff4, 12'hc02, 0, 4, 1, 1'b1);

    repeat (3) @(negedge clk_in);
    rst_in = 1'b0;

    culled_expected = 0;
    phase_start     = 0;
    while (phase_start < NUM_ENTRIES) begin
      // A phase is a run of entries with the same cull_enable.
      phase_end = phase_start;
      while (phase_end + 1 < NUM_ENTRIES &&
             entries[phase_end + 1].cull == entries[phase_start].cull) begin
        phase_end++;
      end
      cull_enable = entries[phase_start].cull;
      for (int i = phase_start; i <= phase_end; i++) begin
        if (is_back_facing(entries[i].normal, entries[i].cull)) begin
          culled_expected++;
        end else begin
          exp_q.push_back(i);
        end
      end
      fork
        write_stream(0, phase_start, phase_end);
        write_stream(1, phase_start, phase_end);
        write_stream(2, phase_start, phase_end);
      join
      while (exp_q.size() != 0 || int'(culled_count) < culled_expected) begin
        @(posedge clk_in);
      end
      @(negedge clk_in);
      check_value($sformatf("culled count after entry %0d", phase_end),
                  culled_expected, culled_count);
      phase_start = phase_end + 1;
    end

    repeat (5) @(negedge clk_in);
    check_value("final culled count", culled_expected, culled_count);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* compile.f */
logic/geom_pkg.sv
logic/fifo_pkg.sv
logic/triangle_if.sv
logic/attr_ram.sv
logic/triangle_fifo.sv
logic/backface_cull.sv
logic/triangle_stream_top.sv
bench/triangle_stream_tb.sv
